// ==== zbt_ctrl.f ====
hw/wb_pkg.sv
hw/zbt_pkg.sv
hw/zbt_if.sv
hw/zbt_decode.sv
hw/zbt_execute.sv
hw/zbt_result.sv
hw/zbt_ctrl_top.sv
sim/tb_clkgen.sv
sim/zbt_sram_model.sv
sim/tb_zbt_ctrl.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_zbt_ctrl
FILELIST  ?= zbt_ctrl.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
PASS_MSG  ?= TEST PASS

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the search for the pass line
run: $(SIM_BIN)
	$(SIM_BIN) | tee /dev/stderr | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/tb_zbt_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_zbt_ctrl;

  localparam int ADDR_W = 10;
  localparam int TMO    = 20;
  localparam int LAT    = 4;

  logic              clk;
  logic              rst_n;
  logic [15:0]       wb0_dat_i;
  logic [15:0]       wb1_dat_i;
  logic [15:0]       wb0_dat_o;
  logic [15:0]       wb1_dat_o;
  logic [ADDR_W+1:1] wb0_adr;
  logic [ADDR_W+1:1] wb1_adr;
  logic              wb0_we;
  logic              wb1_we;
  logic              wb0_stb;
  logic              wb1_stb;
  logic              wb0_cyc;
  logic              wb1_cyc;
  logic [1:0]        wb0_sel;
  logic [1:0]        wb1_sel;
  logic              wb0_ack;
  logic              wb1_ack;
  logic              sram_clk;
  logic              sram_oe;
  logic              sram_we_n;
  logic              sram_cen_n;
  logic              sram_adv_ld_n;
  logic [ADDR_W-1:0] sram_addr;
  logic [31:0]       sram_dq_in;
  logic [31:0]       sram_dq_out;
  logic [3:0]        sram_bw_n;

  // expected contents, one entry per halfword
  logic [15:0] exp_mem [0:(2<<ADDR_W)-1];
  int          errs;
  int          tests_run;
  int          tests_failed;
  int          total_errs;

  tb_clkgen #(.PERIOD(8.0), .RST_CYCLES(8)) tb_clkgen_inst (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  zbt_ctrl_top #(.ADDR_W(ADDR_W)) zbt_ctrl_top_inst (
    .wb_clk_i        (clk),
    .rst_n_i         (rst_n),
    .wb0_dat_i       (wb0_dat_i),
    .wb0_dat_o       (wb0_dat_o),
    .wb0_adr_i       (wb0_adr),
    .wb0_we_i        (wb0_we),
    .wb0_sel_i       (wb0_sel),
    .wb0_stb_i       (wb0_stb),
    .wb0_cyc_i       (wb0_cyc),
    .wb0_ack_o       (wb0_ack),
    .wb1_dat_i       (wb1_dat_i),
    .wb1_dat_o       (wb1_dat_o),
    .wb1_adr_i       (wb1_adr),
    .wb1_we_i        (wb1_we),
    .wb1_sel_i       (wb1_sel),
    .wb1_stb_i       (wb1_stb),
    .wb1_cyc_i       (wb1_cyc),
    .wb1_ack_o       (wb1_ack),
    .sram_clk_o      (sram_clk),
    .sram_addr_o     (sram_addr),
    .sram_dq_i       (sram_dq_in),
    .sram_dq_o       (sram_dq_out),
    .sram_dq_oe_o    (sram_oe),
    .sram_we_n_o     (sram_we_n),
    .sram_bw_n_o     (sram_bw_n),
    .sram_cen_n_o    (sram_cen_n),
    .sram_adv_ld_n_o (sram_adv_ld_n)
  );

  zbt_sram_model #(.ADDR_W(ADDR_W)) zbt_sram_model_inst (
    .clk_i        (sram_clk),
    .addr_i       (sram_addr),
    .ctrl_dq_i    (sram_dq_out),
    .ctrl_dq_oe_i (sram_oe),
    .we_n_i       (sram_we_n),
    .bw_n_i       (sram_bw_n),
    .cen_n_i      (sram_cen_n),
    .adv_ld_n_i   (sram_adv_ld_n),
    .dq_o         (sram_dq_in)
  );

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
      $display("ERR %s: expected %h, actual %h", name, exp, act);
      errs++;
    end
  endtask

  task automatic set_port(input int p, input logic stb, input logic we,
                          input logic [ADDR_W:0] adr, input logic [1:0] sel,
                          input logic [15:0] dat);
    if (p == 0) begin
      wb0_stb   = stb;
      wb0_cyc   = stb;
      wb0_we    = we;
      wb0_adr   = adr;
      wb0_sel   = sel;
      wb0_dat_i = dat;
    end else begin
      wb1_stb   = stb;
      wb1_cyc   = stb;
      wb1_we    = we;
      wb1_adr   = adr;
      wb1_sel   = sel;
      wb1_dat_i = dat;
    end
  endtask

  // byte lanes follow the selects
  task automatic exp_write(input logic [ADDR_W:0] adr, input logic [1:0] sel,
                           input logic [15:0] dat);
    if (sel[0]) exp_mem[adr][7:0] = dat[7:0];
    if (sel[1]) exp_mem[adr][15:8] = dat[15:8];
  endtask

  // one access, returns read data and cycles from stb to ack
  task automatic access(input int p, input logic we, input logic [ADDR_W:0] adr,
                        input logic [1:0] sel, input logic [15:0] dat,
                        output logic [15:0] rd, output int lat);
    logic got;
    got = 1'b0;
    lat = 0;
    @(negedge clk);
    set_port(p, 1'b1, we, adr, sel, dat);
    while (!got && lat < TMO) begin
      @(negedge clk);
      lat++;
      got = (p == 0) ? wb0_ack : wb1_ack;
    end
    if (!got) begin
      $display("port %0d gave no acknowledge within %0d cycles", p, TMO);
      errs++;
      lat = -1;
    end
    rd = (p == 0) ? wb0_dat_o : wb1_dat_o;
    set_port(p, 1'b0, 1'b0, '0, '0, '0);
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errs == 0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: failed with %0d errors", name, errs);
      tests_failed++;
      total_errs += errs;
    end
    errs = 0;
  endtask

  task automatic check_idle(input string name);
    check_val({name, " ack0"}, 32'(1'b0), 32'(wb0_ack));
    check_val({name, " ack1"}, 32'(1'b0), 32'(wb1_ack));
    check_val({name, " cen_n"}, 32'(1'b1), 32'(sram_cen_n));
    check_val({name, " we_n"}, 32'(1'b1), 32'(sram_we_n));
    check_val({name, " oe"}, 32'(1'b0), 32'(sram_oe));
  endtask

  initial begin
    logic [ADDR_W:0] adr;
    logic [ADDR_W:0] adr_b;
    logic [1:0]      sel;
    logic [15:0]     dat;
    logic [15:0]     dat_b;
    logic [15:0]     rd;
    logic [15:0]     rd_b;
    int              lat;
    int              lat_b;
    int              n;
    int              p;
    logic            we;

    void'($urandom(32'h6e24b8a0));
    errs         = 0;
    tests_run    = 0;
    tests_failed = 0;
    total_errs   = 0;
    set_port(0, 1'b0, 1'b0, '0, '0, '0);
    set_port(1, 1'b0, 1'b0, '0, '0, '0);
    // sram fill pattern split into its two halves
    for (int w = 0; w < (1 << ADDR_W); w++) begin
      dat = 16'(w);
      exp_mem[2*w]   = {~dat[3:0], dat[9:0], 2'b01};
      exp_mem[2*w+1] = {10'(w) ^ 10'h2a5, ~dat[9:4]};
    end

    // reset state, sampled on falling edges
    n = 0;
    @(negedge clk);
    while (rst_n !== 1'b1 && n < 100) begin
      check_idle("reset");
      @(negedge clk);
      n++;
    end
    if (rst_n !== 1'b1) begin
      $display("reset never released");
      errs++;
    end
    @(negedge clk);
    check_idle("after_reset");
    finish_test("reset_state");

    // full halfword write then read on each port
    for (int q = 0; q < 2; q++) begin
      adr = ($urandom() % (2 << ADDR_W));
      dat = $urandom();
      access(q, 1'b1, adr, 2'b11, dat, rd, lat);
      check_val("rw_write_lat", LAT, lat);
      exp_write(adr, 2'b11, dat);
      access(q, 1'b0, adr, 2'b11, '0, rd, lat);
      check_val("rw_read_lat", LAT, lat);
      check_val("rw_read_data", exp_mem[adr], rd);
    end
    finish_test("halfword_rw");

    // partial selects, both halves read back
    for (int i = 0; i < 20; i++) begin
      p   = $urandom() % 2;
      adr = ($urandom() % (2 << ADDR_W));
      sel = $urandom();
      dat = $urandom();
      access(p, 1'b1, adr, sel, dat, rd, lat);
      exp_write(adr, sel, dat);
      access(p, 1'b0, {adr[ADDR_W:1], 1'b0}, 2'b11, '0, rd, lat);
      check_val("sel_low_half", exp_mem[{adr[ADDR_W:1], 1'b0}], rd);
      access(p, 1'b0, {adr[ADDR_W:1], 1'b1}, 2'b11, '0, rd, lat);
      check_val("sel_high_half", exp_mem[{adr[ADDR_W:1], 1'b1}], rd);
    end
    finish_test("byte_selects");

    // both ports in the same cycle, writes then reads
    adr   = ($urandom() % (2 << ADDR_W));
    adr_b = adr ^ 11'h200;
    for (int k = 0; k < 2; k++) begin
      we    = (k == 0);
      dat   = $urandom();
      dat_b = $urandom();
      @(negedge clk);
      set_port(0, 1'b1, we, adr, 2'b11, dat);
      set_port(1, 1'b1, we, adr_b, 2'b11, dat_b);
      lat   = -1;
      lat_b = -1;
      n     = 0;
      while ((lat < 0 || lat_b < 0) && n < TMO) begin
        @(negedge clk);
        n++;
        if (lat < 0 && wb0_ack) begin
          lat = n;
          rd  = wb0_dat_o;
          set_port(0, 1'b0, 1'b0, '0, '0, '0);
        end
        if (lat_b < 0 && wb1_ack) begin
          lat_b = n;
          rd_b  = wb1_dat_o;
          set_port(1, 1'b0, 1'b0, '0, '0, '0);
        end
      end
      if (lat < 0 || lat_b < 0) begin
        $display("concurrent access gave no acknowledge within %0d cycles", TMO);
        errs++;
        set_port(0, 1'b0, 1'b0, '0, '0, '0);
        set_port(1, 1'b0, 1'b0, '0, '0, '0);
      end
      check_val("conc_lat0", LAT, lat);
      check_val("conc_lat1", LAT + 1, lat_b);
      if (we) begin
        exp_write(adr, 2'b11, dat);
        exp_write(adr_b, 2'b11, dat_b);
      end else begin
        check_val("conc_data0", exp_mem[adr], rd);
        check_val("conc_data1", exp_mem[adr_b], rd_b);
      end
    end
    finish_test("concurrent");

    // mixed random traffic
    for (int i = 0; i < 200; i++) begin
      p   = $urandom() % 2;
      we  = $urandom();
      adr = ($urandom() % (2 << ADDR_W));
      sel = we ? 2'($urandom()) : 2'b11;
      dat = $urandom();
      repeat ($urandom() % 4) @(negedge clk);
      access(p, we, adr, sel, dat, rd, lat);
      check_val("random_lat", LAT, lat);
      if (we) begin
        exp_write(adr, sel, dat);
      end else begin
        check_val("random_read", exp_mem[adr], rd);
      end
    end
    finish_test("random_traffic");

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errs);
    if (tests_failed == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/zbt_sram_model.sv ====
`timescale 1ns/100ps
`default_nettype none

// pipelined zbt sram, address on one edge, data two edges later
module zbt_sram_model #(
  parameter int ADDR_W = 10
) (
  input  logic              clk_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic [31:0]       ctrl_dq_i,
  input  logic              ctrl_dq_oe_i,
  input  logic              we_n_i,
  input  logic [3:0]        bw_n_i,
  input  logic              cen_n_i,
  input  logic              adv_ld_n_i,
  output logic [31:0]       dq_o
);

  logic [31:0]       mem [0:(1<<ADDR_W)-1];
  // address stage
  logic              v1;
  logic              wr1;
  logic [ADDR_W-1:0] a1;
  logic [3:0]        bw1;
  // read data on the bus
  logic [31:0]       rd_q;

  // fill pattern built from every address bit
  initial begin
    for (int i = 0; i < (1 << ADDR_W); i++) begin
      mem[i] = {10'(i) ^ 10'h2a5, ~10'(i), 10'(i), 2'b01};
    end
    v1   = 1'b0;
    rd_q = '0;
  end

  always @(posedge clk_i) begin
    // data stage of the access sampled on the previous edge
    if (v1 && wr1) begin
      for (int b = 0; b < 4; b++) begin
        if (!bw1[b]) begin
          mem[a1][b*8 +: 8] <= ctrl_dq_i[b*8 +: 8];
        end
      end
    end
    if (v1 && !wr1) begin
      rd_q <= mem[a1];
    end
    v1  <= !cen_n_i && !adv_ld_n_i;
    wr1 <= !we_n_i;
    a1  <= addr_i;
    bw1 <= bw_n_i;
  end

  // controller owns the bus while it drives
  assign dq_o = ctrl_dq_oe_i ? ctrl_dq_i : rd_q;

endmodule

`default_nettype wire

// ==== sim/tb_clkgen.sv ====
`timescale 1ns/100ps
`default_nettype none

// free-running clock and power-on reset for the testbench
module tb_clkgen #(
  parameter real PERIOD     = 8.0,
  parameter int  RST_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD / 2.0) clk_o = ~clk_o;
    end
  end

  // falling reset edge before the first clock edge
  // so the pins are already idle when the sram first samples them
  // release on a falling edge, away from the sampling edge
  initial begin
    rst_n_o = 1'b1;
    #(PERIOD / 4.0) rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// ==== hw/zbt_ctrl_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module zbt_ctrl_top
  import wb_pkg::*, zbt_pkg::*;
#(
  parameter int ADDR_W = 18
) (
  input  logic                wb_clk_i,
  input  logic                rst_n_i,

  // port 0, high priority
  input  logic [WB_DAT_W-1:0] wb0_dat_i,
  output logic [WB_DAT_W-1:0] wb0_dat_o,
  input  logic [ADDR_W+1:1]   wb0_adr_i,
  input  logic                wb0_we_i,
  input  logic [WB_SEL_W-1:0] wb0_sel_i,
  input  logic                wb0_stb_i,
  input  logic                wb0_cyc_i,
  output logic                wb0_ack_o,

  // port 1, low priority
  input  logic [WB_DAT_W-1:0] wb1_dat_i,
  output logic [WB_DAT_W-1:0] wb1_dat_o,
  input  logic [ADDR_W+1:1]   wb1_adr_i,
  input  logic                wb1_we_i,
  input  logic [WB_SEL_W-1:0] wb1_sel_i,
  input  logic                wb1_stb_i,
  input  logic                wb1_cyc_i,
  output logic                wb1_ack_o,

  // sram pins, dq split into in, out and enable
  output logic                sram_clk_o,
  output logic [ADDR_W-1:0]   sram_addr_o,
  input  logic [ZBT_DQ_W-1:0] sram_dq_i,
  output logic [ZBT_DQ_W-1:0] sram_dq_o,
  output logic                sram_dq_oe_o,
  output logic                sram_we_n_o,
  output zbt_bw_t             sram_bw_n_o,
  output logic                sram_cen_n_o,
  output logic                sram_adv_ld_n_o
);

  logic wb0_req;
  logic wb1_req;

  zbt_cmd_if #(.ADDR_W(ADDR_W)) cmd_if ();
  zbt_rsp_if                    rsp_if ();

  // sram runs on the bus clock
  assign sram_clk_o = wb_clk_i;

  assign wb0_req = wb0_stb_i & wb0_cyc_i;
  assign wb1_req = wb1_stb_i & wb1_cyc_i;

  zbt_decode #(
    .ADDR_W (ADDR_W)
  ) zbt_decode_inst (
    .wb_clk_i  (wb_clk_i),
    .rst_n_i   (rst_n_i),
    .wb0_dat_i (wb0_dat_i),
    .wb0_adr_i (wb0_adr_i),
    .wb0_we_i  (wb0_we_i),
    .wb0_sel_i (wb0_sel_i),
    .wb0_stb_i (wb0_stb_i),
    .wb0_cyc_i (wb0_cyc_i),
    .wb1_dat_i (wb1_dat_i),
    .wb1_adr_i (wb1_adr_i),
    .wb1_we_i  (wb1_we_i),
    .wb1_sel_i (wb1_sel_i),
    .wb1_stb_i (wb1_stb_i),
    .wb1_cyc_i (wb1_cyc_i),
    .cmd       (cmd_if.decode)
  );

  zbt_execute #(
    .ADDR_W (ADDR_W)
  ) zbt_execute_inst (
    .wb_clk_i        (wb_clk_i),
    .rst_n_i         (rst_n_i),
    .cmd             (cmd_if.execute),
    .rsp             (rsp_if.execute),
    .sram_addr_o     (sram_addr_o),
    .sram_dq_i       (sram_dq_i),
    .sram_dq_o       (sram_dq_o),
    .sram_dq_oe_o    (sram_dq_oe_o),
    .sram_we_n_o     (sram_we_n_o),
    .sram_bw_n_o     (sram_bw_n_o),
    .sram_cen_n_o    (sram_cen_n_o),
    .sram_adv_ld_n_o (sram_adv_ld_n_o),
    .wb0_req_i       (wb0_req),
    .wb1_req_i       (wb1_req)
  );

  zbt_result zbt_result_inst (
    .wb_clk_i   (wb_clk_i),
    .rst_n_i    (rst_n_i),
    .rsp        (rsp_if.result),
    .wb0_adr1_i (wb0_adr_i[1]),
    .wb1_adr1_i (wb1_adr_i[1]),
    .wb0_dat_o  (wb0_dat_o),
    .wb1_dat_o  (wb1_dat_o),
    .wb0_ack_o  (wb0_ack_o),
    .wb1_ack_o  (wb1_ack_o)
  );

endmodule

`default_nettype wire

// ==== hw/zbt_result.sv ====
`timescale 1ns/100ps
`default_nettype none

module zbt_result
  import wb_pkg::*;
(
  input  logic                wb_clk_i,
  input  logic                rst_n_i,

  zbt_rsp_if.result           rsp,

  // half select, held by the master until ack
  input  logic                wb0_adr1_i,
  input  logic                wb1_adr1_i,

  output logic [WB_DAT_W-1:0] wb0_dat_o,
  output logic [WB_DAT_W-1:0] wb1_dat_o,
  output logic                wb0_ack_o,
  output logic                wb1_ack_o
);

  logic [WB_NPORT-1:0]               adr1;
  logic [WB_NPORT-1:0][WB_DAT_W-1:0] dat_q;
  logic [WB_NPORT-1:0]               ack_q;

  assign adr1 = {wb1_adr1_i, wb0_adr1_i};

  // read halfword per port
  // only reads capture, so the last read value stays visible
  always_ff @(posedge wb_clk_i) begin
    for (int p = 0; p < WB_NPORT; p++) begin
      if (rsp.capture[p]) begin
        dat_q[p] <= rsp.rd_word.half[adr1[p]];
      end
    end
  end

  // ack follows capture by one cycle, same cycle as the data
  always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q <= '0;
    end else begin
      ack_q <= rsp.ack_stg;
    end
  end

  assign wb0_dat_o = dat_q[PORT0];
  assign wb1_dat_o = dat_q[PORT1];
  assign wb0_ack_o = ack_q[PORT0];
  assign wb1_ack_o = ack_q[PORT1];

endmodule

`default_nettype wire

// ==== hw/zbt_execute.sv ====
`timescale 1ns/100ps
`default_nettype none

module zbt_execute
  import wb_pkg::*, zbt_pkg::*;
#(
  parameter int ADDR_W = 18
) (
  input  logic                wb_clk_i,
  input  logic                rst_n_i,

  zbt_cmd_if.execute          cmd,
  zbt_rsp_if.execute          rsp,

  output logic [ADDR_W-1:0]   sram_addr_o,
  input  logic [ZBT_DQ_W-1:0] sram_dq_i,
  output logic [ZBT_DQ_W-1:0] sram_dq_o,
  output logic                sram_dq_oe_o,
  output logic                sram_we_n_o,
  output zbt_bw_t             sram_bw_n_o,
  output logic                sram_cen_n_o,
  output logic                sram_adv_ld_n_o,

  input  logic                wb0_req_i,
  input  logic                wb1_req_i
);

  // bit k set during cycle k+1 after the load
  logic [WB_NPORT-1:0][ZBT_DEPTH-1:0] cnt_q;
  logic [WB_NPORT-1:0]                load_p;
  logic [WB_NPORT-1:0]                we_q;
  logic [WB_NPORT-1:0]                wr_stg;
  zbt_word_u [WB_NPORT-1:0]           wr_word_q;

  // split the shared load by owner
  always_comb begin
    for (int p = 0; p < WB_NPORT; p++) begin
      load_p[p] = cmd.load & (cmd.port == port_id_t'(p));
    end
  end

  // stage counters and access direction per port
  always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
      we_q  <= '0;
    end else begin
      for (int p = 0; p < WB_NPORT; p++) begin
        cnt_q[p] <= {cnt_q[p][ZBT_DEPTH-2:0], load_p[p]};
        if (load_p[p]) begin
          we_q[p] <= cmd.we;
        end
      end
    end
  end

  // write word kept until its data cycle
  always_ff @(posedge wb_clk_i) begin
    for (int p = 0; p < WB_NPORT; p++) begin
      if (load_p[p]) begin
        wr_word_q[p] <= cmd.wdata;
      end
    end
  end

  // stage decode
  // write data in cycle ZBT_LAT, read data on the pins in cycle ZBT_LAT+1
  always_comb begin
    for (int p = 0; p < WB_NPORT; p++) begin
      cmd.busy[p]    = |cnt_q[p];
      wr_stg[p]      = cnt_q[p][ZBT_LAT-1] & we_q[p];
      rsp.capture[p] = cnt_q[p][ZBT_LAT] & ~we_q[p];
      // result registers this, ack lands one cycle later
      rsp.ack_stg[p] = cnt_q[p][ZBT_LAT];
    end
  end

  assign rsp.rd_word = zbt_word_u'(sram_dq_i);

  // loads are one per cycle, so two write stages never overlap
  assign sram_dq_oe_o = |wr_stg;
  assign sram_dq_o    = wr_stg[PORT0] ? wr_word_q[PORT0].word : wr_word_q[PORT1].word;

  // sram control pins, valid from cycle 1
  always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sram_we_n_o  <= 1'b1;
      sram_bw_n_o  <= '1;
      sram_cen_n_o <= 1'b1;
    end else begin
      sram_we_n_o  <= ~(cmd.load & cmd.we);
      if (cmd.load) begin
        sram_bw_n_o <= cmd.bw;
      end
      // clock enabled while anyone is asking
      sram_cen_n_o <= ~(wb0_req_i | wb1_req_i);
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (cmd.load) begin
      sram_addr_o <= cmd.addr;
    end
  end

  // no bursts, every cycle is a fresh load
  assign sram_adv_ld_n_o = 1'b0;

endmodule

`default_nettype wire

// ==== hw/zbt_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module zbt_decode
  import wb_pkg::*, zbt_pkg::*;
#(
  parameter int ADDR_W = 18
) (
  input  logic                wb_clk_i,
  input  logic                rst_n_i,

  input  logic [WB_DAT_W-1:0] wb0_dat_i,
  input  logic [ADDR_W+1:1]   wb0_adr_i,
  input  logic                wb0_we_i,
  input  logic [WB_SEL_W-1:0] wb0_sel_i,
  input  logic                wb0_stb_i,
  input  logic                wb0_cyc_i,

  input  logic [WB_DAT_W-1:0] wb1_dat_i,
  input  logic [ADDR_W+1:1]   wb1_adr_i,
  input  logic                wb1_we_i,
  input  logic [WB_SEL_W-1:0] wb1_sel_i,
  input  logic                wb1_stb_i,
  input  logic                wb1_cyc_i,

  zbt_cmd_if.decode           cmd
);

  logic                req0;
  logic                req1;
  logic                load0;
  logic                load1;
  port_id_t            win;
  port_id_t            last_q;
  logic [WB_DAT_W-1:0] dat_mux;
  logic [ADDR_W+1:1]   adr_mux;
  logic [WB_SEL_W-1:0] sel_mux;
  logic                we_mux;
  zbt_word_u           wr_word;
  zbt_bw_t             bw;

  assign req0 = wb0_stb_i & wb0_cyc_i;
  assign req1 = wb1_stb_i & wb1_cyc_i;

  // fixed priority
  // port 1 only gets in when port 0 is idle or already in flight
  assign load0 = req0 & ~cmd.busy[PORT0];
  assign load1 = req1 & ~cmd.busy[PORT1] & (~req0 | cmd.busy[PORT0]);

  // idle cycles keep the mux on the last winner
  // so the command bus does not toggle for nothing
  always_comb begin
    if (load0) begin
      win = PORT0;
    end else if (load1) begin
      win = PORT1;
    end else begin
      win = last_q;
    end
  end

  always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      last_q <= PORT0;
    end else if (load0 | load1) begin
      last_q <= win;
    end
  end

  // request of the selected port
  always_comb begin
    if (win == PORT0) begin
      dat_mux = wb0_dat_i;
      adr_mux = wb0_adr_i;
      sel_mux = wb0_sel_i;
      we_mux  = wb0_we_i;
    end else begin
      dat_mux = wb1_dat_i;
      adr_mux = wb1_adr_i;
      sel_mux = wb1_sel_i;
      we_mux  = wb1_we_i;
    end
  end

  // adr bit 1 picks the half
  // selects become byte enables on that half only
  always_comb begin
    wr_word                          = '0;
    wr_word.half[adr_mux[1]]         = dat_mux;
    bw                               = '1;
    bw[adr_mux[1]*WB_SEL_W +: WB_SEL_W] = ~sel_mux;
  end

  assign cmd.load  = load0 | load1;
  assign cmd.port  = win;
  // drop the halfword bit, sram is word addressed
  assign cmd.addr  = adr_mux[ADDR_W+1:2];
  assign cmd.we    = we_mux;
  assign cmd.bw    = bw;
  assign cmd.wdata = wr_word;

endmodule

`default_nettype wire

// ==== hw/zbt_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// command path from arbitration to the pin stage
interface zbt_cmd_if
  import wb_pkg::*, zbt_pkg::*;
#(
  parameter int ADDR_W = 18
) ();

  // single-cycle pulse, at most one per cycle
  logic                load;
  // owner of the load
  port_id_t            port;
  logic [ADDR_W-1:0]   addr;
  logic                we;
  zbt_bw_t             bw;
  // data already sitting in the selected half
  zbt_word_u           wdata;
  // per-port access in flight, fed back to arbitration
  logic [WB_NPORT-1:0] busy;

  modport decode (
    output load,
    output port,
    output addr,
    output we,
    output bw,
    output wdata,
    input  busy
  );

  modport execute (
    input  load,
    input  port,
    input  addr,
    input  we,
    input  bw,
    input  wdata,
    output busy
  );

endinterface

// response path from the pin stage to the wishbone side
interface zbt_rsp_if
  import wb_pkg::*, zbt_pkg::*;
();

  // read word valid on the pins this cycle
  logic [WB_NPORT-1:0] capture;
  // one cycle before ack
  logic [WB_NPORT-1:0] ack_stg;
  zbt_word_u           rd_word;

  modport execute (
    output capture,
    output ack_stg,
    output rd_word
  );

  modport result (
    input capture,
    input ack_stg,
    input rd_word
  );

endinterface

`default_nettype wire

// ==== hw/zbt_pkg.sv ====
`default_nettype none

package zbt_pkg;

  // sram data bus, two halfwords per word
  localparam int ZBT_DQ_W   = 32;
  localparam int ZBT_HALF_W = ZBT_DQ_W / 2;

  // one active-low write enable per byte
  localparam int ZBT_BW_W = ZBT_DQ_W / 8;

  // read data appears this many cycles after the address cycle
  localparam int ZBT_LAT = 2;

  // per-port stage counter length
  // covers address cycle, latency and the ack cycle
  localparam int ZBT_DEPTH = ZBT_LAT + 2;

  // bw_n pins, low enables the byte
  typedef logic [ZBT_BW_W-1:0] zbt_bw_t;

  // one sram word
  // word is what the pins see, half is indexed by wishbone adr bit 1
  typedef union packed {
    logic [ZBT_DQ_W-1:0]        word;
    logic [1:0][ZBT_HALF_W-1:0] half;
  } zbt_word_u;

endpackage

`default_nettype wire

// ==== hw/wb_pkg.sv ====
`default_nettype none

package wb_pkg;

  // slave data path
  // one halfword per access
  localparam int WB_DAT_W = 16;

  // one select bit per byte lane
  localparam int WB_SEL_W = WB_DAT_W / 8;

  // two slave ports share one sram
  localparam int WB_NPORT = 2;

  // port names
  // port 0 always wins a tie
  typedef enum logic {
    PORT0 = 1'b0,
    PORT1 = 1'b1
  } port_id_t;

endpackage

`default_nettype wire
